//--- all.f
common/mips_isa_pkg.sv
common/cpu_ctrl_pkg.sv
datapath/alu.sv
datapath/reg_file.sv
control/instr_decode.sv
control/cpu_control.sv
src/pc_unit.sv
src/mips_cpu_bus.sv
test/mips_cpu_bus_chk.sv
test/mips_cpu_bus_tb.sv

//--- Bender.yml
package:
  name: mips_cpu_bus

sources:
  - common/mips_isa_pkg.sv
  - common/cpu_ctrl_pkg.sv
  - datapath/alu.sv
  - datapath/reg_file.sv
  - control/instr_decode.sv
  - control/cpu_control.sv
  - src/pc_unit.sv
  - src/mips_cpu_bus.sv
  - target: test
    files:
      - test/mips_cpu_bus_chk.sv
      - test/mips_cpu_bus_tb.sv

//--- test/mips_cpu_bus_tb.sv
// Testbench for mips_cpu_bus with clock, reset, Avalon memory model with random stalls and directed tests
`timescale 1ns/1ps

module mips_cpu_bus_tb;
    import mips_isa_pkg::*;

    localparam word_t RESET_VECTOR = 32'hBFC0_0000;
    localparam word_t DATA_BASE    = 32'h0000_1000;
    localparam int    PROG_WORDS   = 64;
    // Longest run with all stalls stays far below this
    localparam int    TIMEOUT_CYCLES = 3000;

    // Scratch registers used by the programs
    localparam reg_idx_t T0   = 5'd8;
    localparam reg_idx_t T1   = 5'd9;
    localparam reg_idx_t T2   = 5'd10;
    localparam reg_idx_t BASE = 5'd12;

    logic       clk;
    logic       reset;
    logic       waitrequest = 1'b0;
    word_t      readdata = '0;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       write;
    logic       read;
    word_t      writedata;
    logic [3:0] byteenable;

    word_t       prog_mem [PROG_WORDS];
    word_t       data_mem [16];
    int          prog_len;
    int          cycle_count = 0;
    logic [31:0] rng_state = 32'd41;
    int          stall_left = 0;
    logic        new_req = 1'b1;

    mips_cpu_bus #(.reset_vector(RESET_VECTOR)) i_dut (
        .clk, .reset, .active, .register_v0, .address, .write, .read,
        .waitrequest, .writedata, .byteenable, .readdata
    );

    bind mips_cpu_bus mips_cpu_bus_chk i_chk (
        .clk, .reset, .active, .read, .write, .waitrequest, .address, .writedata
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                                $time, what, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles, the CPU never halted", cycle_count));
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic word_t next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Avalon slave with 0 to 2 stall cycles per request and the response set up on the falling edge
    always @(negedge clk) begin : mem_model
        word_t offset;
        offset = address - RESET_VECTOR;
        if (!(read === 1'b1 || write === 1'b1)) begin
            waitrequest <= 1'b0;
            new_req = 1'b1;
        end else begin
            // Word accesses only, all four lanes on every request
            check_value("byteenable", {28'd0, byteenable}, 32'h0000_000F);
            if (new_req) begin
                stall_left = next_random() % 3;
                new_req = 1'b0;
            end
            if (stall_left > 0) begin
                waitrequest <= 1'b1;
                stall_left--;
            end else begin
                // Accepted on the next rising edge
                waitrequest <= 1'b0;
                new_req = 1'b1;
                if (read && offset < PROG_WORDS * 4) begin
                    readdata <= prog_mem[offset[7:2]];
                end else if (address[31:6] == DATA_BASE[31:6]) begin
                    if (write) begin
                        data_mem[address[5:2]] = writedata;
                    end else begin
                        readdata <= data_mem[address[5:2]];
                    end
                end else begin
                    abort_run($sformatf("bus access to unmapped address %h at %0t ns",
                                        address, $time));
                end
            end
        end
    end

    // Hand assembler for the three encodings
    function automatic word_t r_op(input funct_t f, input reg_idx_t rs, input reg_idx_t rt,
                                   input reg_idx_t rd, input logic [4:0] sh);
        return {6'd0, rs, rt, rd, sh, f};
    endfunction

    function automatic word_t i_op(input opcode_t op, input reg_idx_t rs, input reg_idx_t rt,
                                   input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_op(input opcode_t op, input logic [25:0] tgt);
        return {op, tgt};
    endfunction

    // Jump field for a program slot
    function automatic logic [25:0] target_of(input int idx);
        word_t addr;
        addr = RESET_VECTOR + 4 * idx;
        return addr[27:2];
    endfunction

    // Set-less-than result from the top bits first, then the remaining 31 bits
    function automatic word_t set_less(input word_t a, input word_t b, input logic is_signed);
        logic lt;
        if (a[31] != b[31]) begin
            // Signed order favours the negative one, unsigned order the clear top bit
            lt = is_signed ? a[31] : b[31];
        end else begin
            lt = (a[30:0] < b[30:0]);
        end
        return {31'd0, lt};
    endfunction

    task automatic start_program();
        prog_len = 0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog_mem[i] = '0;
        end
        // Data words preset to the inverted address
        for (int i = 0; i < 16; i++) begin
            data_mem[i] = ~(DATA_BASE + 4 * i);
        end
    endtask

    task automatic emit(input word_t w);
        prog_mem[prog_len] = w;
        prog_len++;
    endtask

    task automatic emit_halt();
        emit(r_op(F_JR, REG_ZERO, REG_ZERO, REG_ZERO, 5'd0));
    endtask

    task automatic load_const(input reg_idx_t r, input word_t value);
        emit(i_op(OP_LUI, REG_ZERO, r, value[31:16]));
        emit(i_op(OP_ORI, r, r, value[15:0]));
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset <= 1'b1;
        repeat (5) @(negedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_halt();
        @(negedge clk);
        while (active) begin
            @(negedge clk);
        end
    endtask

    // Two operands in t0 and t1, one instruction writing v0, then halt
    task automatic run_case(input string name, input word_t a, input word_t b,
                            input word_t w, input word_t exp);
        start_program();
        load_const(T0, a);
        load_const(T1, b);
        emit(w);
        emit_halt();
        apply_reset();
        wait_halt();
        check_value(name, register_v0, exp);
    endtask

    task automatic alu_register_ops();
        word_t a;
        word_t b;
        a = 32'hFFFF_FFF9;
        b = 32'h0000_0005;
        run_case("ADDU", a, b, r_op(F_ADDU, T0, T1, REG_V0, 5'd0), a + b);
        run_case("SUBU", a, b, r_op(F_SUBU, T0, T1, REG_V0, 5'd0), a - b);
        run_case("AND", a, b, r_op(F_AND, T0, T1, REG_V0, 5'd0), a & b);
        run_case("OR", a, b, r_op(F_OR, T0, T1, REG_V0, 5'd0), a | b);
        run_case("XOR", a, b, r_op(F_XOR, T0, T1, REG_V0, 5'd0), a ^ b);
        run_case("SLT", a, b, r_op(F_SLT, T0, T1, REG_V0, 5'd0), set_less(a, b, 1'b1));
        run_case("SLTU", a, b, r_op(F_SLTU, T0, T1, REG_V0, 5'd0), set_less(a, b, 1'b0));
    endtask

    task automatic alu_immediate_ops();
        word_t a;
        a = 32'hFFFF_8001;
        // Negative immediate is sign extended
        run_case("ADDIU", a, 0, i_op(OP_ADDIU, T0, REG_V0, 16'hFFF0), a + 32'hFFFF_FFF0);
        run_case("ANDI", a, 0, i_op(OP_ANDI, T0, REG_V0, 16'hF0F0), a & 32'h0000_F0F0);
        run_case("ORI", a, 0, i_op(OP_ORI, T0, REG_V0, 16'h8421), a | 32'h0000_8421);
        run_case("XORI", a, 0, i_op(OP_XORI, T0, REG_V0, 16'hFFFF), a ^ 32'h0000_FFFF);
        run_case("SLTI", a, 0, i_op(OP_SLTI, T0, REG_V0, 16'h0003),
                 set_less(a, 32'h0000_0003, 1'b1));
        run_case("SLTIU", a, 0, i_op(OP_SLTIU, T0, REG_V0, 16'hFFFF),
                 set_less(a, 32'hFFFF_FFFF, 1'b0));
        run_case("LUI", a, 0, i_op(OP_LUI, REG_ZERO, REG_V0, 16'hABCD), 32'hABCD_0000);
        run_case("SLL", a, 0, r_op(F_SLL, REG_ZERO, T0, REG_V0, 5'd4), {a[27:0], 4'h0});
        run_case("SRL", a, 0, r_op(F_SRL, REG_ZERO, T0, REG_V0, 5'd4), {4'h0, a[31:4]});
        run_case("SRA", a, 0, r_op(F_SRA, REG_ZERO, T0, REG_V0, 5'd4),
                 {{4{a[31]}}, a[31:4]});
    endtask

    // Each correct path adds its own bit to v0 and each wrong path a high bit
    task automatic branch_and_jump();
        start_program();
        emit(i_op(OP_ADDIU, REG_ZERO, T0, 16'd5));
        emit(i_op(OP_ADDIU, REG_ZERO, T1, 16'd5));
        emit(i_op(OP_BEQ, T0, T1, 16'd1));
        emit(i_op(OP_ADDIU, REG_V0, REG_V0, 16'h0100));
        emit(i_op(OP_ADDIU, REG_V0, REG_V0, 16'h0001));
        emit(i_op(OP_ADDIU, REG_ZERO, T2, 16'd6));
        // Untaken branch in slot 6
        emit(i_op(OP_BEQ, T0, T2, 16'd1));
        emit(i_op(OP_ADDIU, REG_V0, REG_V0, 16'h0002));
        emit(i_op(OP_BNE, T0, T2, 16'd1));
        emit(i_op(OP_ADDIU, REG_V0, REG_V0, 16'h0200));
        emit(i_op(OP_ADDIU, REG_V0, REG_V0, 16'h0004));
        emit(j_op(OP_J, target_of(13)));
        emit(i_op(OP_ADDIU, REG_V0, REG_V0, 16'h0400));
        emit(i_op(OP_ADDIU, REG_V0, REG_V0, 16'h0008));
        // Link from slot 14 holds the address of slot 15
        emit(j_op(OP_JAL, target_of(16)));
        emit(i_op(OP_ADDIU, REG_V0, REG_V0, 16'h0800));
        emit(i_op(OP_ADDIU, REG_V0, REG_V0, 16'h0010));
        emit(i_op(OP_ADDIU, REG_ZERO, BASE, 16'h1000));
        emit(i_op(OP_SW, BASE, REG_V0, 16'h0000));
        emit(r_op(F_ADDU, REG_RA, REG_ZERO, REG_V0, 5'd0));
        emit_halt();
        apply_reset();
        wait_halt();
        check_value("branch path count", data_mem[0], 32'h0000_001F);
        check_value("JAL link", register_v0, RESET_VECTOR + 4 * 15);
    endtask

    task automatic store_then_load();
        word_t value;
        value = next_random();
        start_program();
        load_const(T0, value);
        emit(i_op(OP_ADDIU, REG_ZERO, BASE, 16'h1010));
        // Negative offset gives address 0x1008 which is data word 2
        emit(i_op(OP_SW, BASE, T0, 16'hFFF8));
        emit(i_op(OP_LW, BASE, REG_V0, 16'hFFF8));
        emit_halt();
        apply_reset();
        wait_halt();
        check_value("stored word", data_mem[2], value);
        check_value("LW result", register_v0, value);
    endtask

    task automatic zero_register_writes();
        start_program();
        emit(i_op(OP_ADDIU, REG_ZERO, REG_V0, 16'h0077));
        emit(i_op(OP_ORI, REG_ZERO, REG_ZERO, 16'h0055));
        load_const(T0, 32'h0000_1234);
        emit(r_op(F_ADDU, T0, T0, REG_ZERO, 5'd0));
        emit(r_op(F_ADDU, REG_V0, REG_ZERO, REG_V0, 5'd0));
        emit_halt();
        apply_reset();
        wait_halt();
        check_value("v0 plus r0", register_v0, 32'h0000_0077);
    endtask

    task automatic halt_and_restart();
        start_program();
        emit(i_op(OP_ADDIU, REG_ZERO, REG_V0, 16'h002A));
        emit_halt();
        apply_reset();
        wait_halt();
        check_value("v0 at halt", register_v0, 32'h0000_002A);
        // Bus stays idle while halted
        repeat (20) begin
            @(negedge clk);
            check_value("active while halted", {31'd0, active}, 32'd0);
            check_value("read and write while halted", {30'd0, read, write}, 32'd0);
        end
        apply_reset();
        check_value("fetch address after reset", address, RESET_VECTOR);
        check_value("read after reset", {31'd0, read}, 32'd1);
        check_value("active after reset", {31'd0, active}, 32'd1);
        check_value("v0 after reset", register_v0, 32'd0);
        wait_halt();
        check_value("v0 after restart", register_v0, 32'h0000_002A);
    endtask

    initial begin
        reset = 1'b1;
        alu_register_ops();
        alu_immediate_ops();
        branch_and_jump();
        store_then_load();
        zero_register_writes();
        halt_and_restart();
        if (i_dut.i_chk.fail_count != 0) begin
            abort_run($sformatf("%0d bus protocol assertions failed",
                                i_dut.i_chk.fail_count));
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- test/mips_cpu_bus_chk.sv
// Avalon master protocol assertions for mips_cpu_bus, attached by bind
`timescale 1ns/1ps

module mips_cpu_bus_chk (
    input logic                clk,
    input logic                reset,
    input logic                active,
    input logic                read,
    input logic                write,
    input logic                waitrequest,
    input mips_isa_pkg::word_t address,
    input mips_isa_pkg::word_t writedata
);
    // Failed assertions, read by the testbench at the end
    int fail_count = 0;

    // One transfer direction at a time
    a_single_dir: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else begin
            fail_count++;
            $error("read and write asserted together");
        end

    // Stalled request stays unchanged until accepted
    a_hold_request: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(read) && $stable(write) && $stable(writedata))
        else begin
            fail_count++;
            $error("request changed while waitrequest was high");
        end

    // Halted core leaves the bus alone
    a_idle_halted: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else begin
            fail_count++;
            $error("bus access while inactive");
        end

endmodule

//--- src/mips_cpu_bus.sv
// CPU top level: control, decode, register file, ALU and PC tied to the Avalon master port
`timescale 1ns/1ps

module mips_cpu_bus #(
    parameter mips_isa_pkg::word_t reset_vector = cpu_ctrl_pkg::DEFAULT_RESET_VECTOR
) (
    input  logic                clk,
    input  logic                reset,
    output logic                active,
    output mips_isa_pkg::word_t register_v0,

    // Avalon-MM master
    output mips_isa_pkg::word_t address,
    output logic                write,
    output logic                read,
    input  logic                waitrequest,
    output mips_isa_pkg::word_t writedata,
    output logic [3:0]          byteenable,
    input  mips_isa_pkg::word_t readdata
);
    import mips_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    instr_t   instr;
    ctrl_t    ctrl;
    bus_req_t bus;
    word_t    pc;
    logic     pc_advance;
    word_t    rs_data;
    word_t    rt_data;
    word_t    imm_ext;
    word_t    alu_b;
    word_t    alu_result;
    logic     alu_zero;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    // Immediate extension and ALU B operand select
    assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, instr.i.imm}
                                       : {{16{instr.i.imm[15]}}, instr.i.imm};
    assign alu_b   = ctrl.use_imm ? imm_ext : rt_data;

    // Request struct out to the bus pins, word accesses only
    assign address    = bus.address;
    assign read       = bus.read;
    assign write      = bus.write;
    assign writedata  = bus.writedata;
    assign byteenable = 4'b1111;

    cpu_control i_control (
        .clk, .reset, .waitrequest, .readdata, .pc, .ctrl, .alu_result,
        .rs_data, .rt_data, .instr, .bus, .rf_we, .rf_waddr, .rf_wdata,
        .pc_advance, .active
    );

    instr_decode i_decode (.instr, .ctrl);

    reg_file i_reg_file (
        .clk, .reset,
        .raddr_a(instr.i.rs), .raddr_b(instr.i.rt),
        .rdata_a(rs_data), .rdata_b(rt_data),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .v0(register_v0)
    );

    alu i_alu (
        .op(ctrl.alu_op), .a(rs_data), .b(alu_b), .shamt(instr.r.shamt),
        .result(alu_result), .zero(alu_zero)
    );

    pc_unit #(.reset_vector(reset_vector)) i_pc_unit (
        .clk, .reset, .advance(pc_advance), .ctrl,
        .imm(instr.i.imm), .target(instr.j.target),
        .rs_data, .alu_zero, .pc
    );

endmodule

//--- src/pc_unit.sv
// Program counter with sequential, branch, jump and jump-register next address
`timescale 1ns/1ps

module pc_unit #(
    parameter mips_isa_pkg::word_t reset_vector = cpu_ctrl_pkg::DEFAULT_RESET_VECTOR
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                advance,
    input  cpu_ctrl_pkg::ctrl_t ctrl,
    input  logic [15:0]         imm,
    input  logic [25:0]         target,
    input  mips_isa_pkg::word_t rs_data,
    input  logic                alu_zero,
    output mips_isa_pkg::word_t pc
);
    import mips_isa_pkg::*;

    word_t pc_plus4;
    word_t branch_target;
    word_t jump_target;
    word_t pc_next;
    logic  branch_taken;

    assign pc_plus4 = pc + 32'd4;

    // Word offset relative to the following instruction, no delay slot
    assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
    assign jump_target   = {pc_plus4[31:28], target, 2'b00};

    // ALU subtracts rs and rt for branches, so zero means equal
    assign branch_taken = (ctrl.branch_eq & alu_zero) | (ctrl.branch_ne & ~alu_zero);

    always_comb begin
        if (ctrl.jump_reg) begin
            pc_next = rs_data;
        end else if (ctrl.jump) begin
            pc_next = jump_target;
        end else if (branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (advance) begin
            pc <= pc_next;
        end
    end

endmodule

//--- control/cpu_control.sv
// Fetch / execute / memory FSM with instruction register, write-back select and bus request
`timescale 1ns/1ps

module cpu_control (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   waitrequest,
    input  mips_isa_pkg::word_t    readdata,
    input  mips_isa_pkg::word_t    pc,
    input  cpu_ctrl_pkg::ctrl_t    ctrl,
    input  mips_isa_pkg::word_t    alu_result,
    input  mips_isa_pkg::word_t    rs_data,
    input  mips_isa_pkg::word_t    rt_data,
    output mips_isa_pkg::instr_t   instr,
    output cpu_ctrl_pkg::bus_req_t bus,
    output logic                   rf_we,
    output mips_isa_pkg::reg_idx_t rf_waddr,
    output mips_isa_pkg::word_t    rf_wdata,
    output logic                   pc_advance,
    output logic                   active
);
    import mips_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    cpu_state_t state;
    cpu_state_t state_next;
    logic       is_mem;
    logic       halt_req;

    assign is_mem   = ctrl.mem_read | ctrl.mem_write;
    // JR to address zero ends the program
    assign halt_req = ctrl.jump_reg && (rs_data == '0);
    assign active   = (state != HALT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    // Instruction register, loaded on the accepting edge of the fetch
    always_ff @(posedge clk) begin
        if (state == FETCH && !waitrequest) begin
            instr <= instr_t'(readdata);
        end
    end

    always_comb begin
        state_next = state;
        bus        = '0;
        rf_we      = 1'b0;
        pc_advance = 1'b0;
        case (state)
            FETCH: begin
                bus.address = pc;
                bus.read    = 1'b1;
                if (!waitrequest) begin
                    state_next = EXEC;
                end
            end
            EXEC: begin
                // Memory ops finish in MEM, everything else retires here
                if (is_mem) begin
                    state_next = MEM;
                end else begin
                    rf_we      = ctrl.reg_write;
                    pc_advance = 1'b1;
                    state_next = halt_req ? HALT : FETCH;
                end
            end
            MEM: begin
                // Effective address from the ALU stays fixed through stalls
                bus.address   = alu_result;
                bus.read      = ctrl.mem_read;
                bus.write     = ctrl.mem_write;
                bus.writedata = rt_data;
                if (!waitrequest) begin
                    rf_we      = ctrl.mem_read;
                    pc_advance = 1'b1;
                    state_next = FETCH;
                end
            end
            HALT: begin
                // Bus idle until the next reset
                state_next = HALT;
            end
        endcase
    end

    // Write-back destination
    always_comb begin
        if (ctrl.link) begin
            rf_waddr = REG_RA;
        end else if (ctrl.dest_is_rd) begin
            rf_waddr = instr.r.rd;
        end else begin
            rf_waddr = instr.i.rt;
        end
    end

    // Write-back value: return address, load data or ALU result
    always_comb begin
        if (ctrl.link) begin
            rf_wdata = pc + 32'd4;
        end else if (ctrl.mem_read) begin
            rf_wdata = readdata;
        end else begin
            rf_wdata = alu_result;
        end
    end

endmodule

//--- control/instr_decode.sv
// Instruction decoder from the fetched word to the control struct
`timescale 1ns/1ps

module instr_decode (
    input  mips_isa_pkg::instr_t instr,
    output cpu_ctrl_pkg::ctrl_t  ctrl
);
    import mips_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    always_comb begin
        // Everything off unless the opcode says otherwise
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        case (instr.i.opcode)
            OP_R: begin
                ctrl.reg_write  = 1'b1;
                ctrl.dest_is_rd = 1'b1;
                case (instr.r.funct)
                    F_ADDU: ctrl.alu_op = ALU_ADD;
                    F_SUBU: ctrl.alu_op = ALU_SUB;
                    F_AND:  ctrl.alu_op = ALU_AND;
                    F_OR:   ctrl.alu_op = ALU_OR;
                    F_XOR:  ctrl.alu_op = ALU_XOR;
                    F_SLT:  ctrl.alu_op = ALU_SLT;
                    F_SLTU: ctrl.alu_op = ALU_SLTU;
                    F_SLL:  ctrl.alu_op = ALU_SLL;
                    F_SRL:  ctrl.alu_op = ALU_SRL;
                    F_SRA:  ctrl.alu_op = ALU_SRA;
                    F_JR: begin
                        ctrl.reg_write  = 1'b0;
                        ctrl.dest_is_rd = 1'b0;
                        ctrl.jump_reg   = 1'b1;
                    end
                    default: begin
                        // Unsupported function, treated as a no-op
                        ctrl.reg_write  = 1'b0;
                        ctrl.dest_is_rd = 1'b0;
                        ctrl.illegal    = 1'b1;
                    end
                endcase
            end
            OP_J: ctrl.jump = 1'b1;
            OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            // Compare by subtraction, pc_unit reads the zero flag
            OP_BEQ: begin
                ctrl.alu_op    = ALU_SUB;
                ctrl.branch_eq = 1'b1;
            end
            OP_BNE: begin
                ctrl.alu_op    = ALU_SUB;
                ctrl.branch_ne = 1'b1;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LUI: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = (instr.i.opcode == OP_SLTI)  ? ALU_SLT  :
                                 (instr.i.opcode == OP_SLTIU) ? ALU_SLTU :
                                 (instr.i.opcode == OP_LUI)   ? ALU_LUI  : ALU_ADD;
            end
            // Logical immediates are zero extended
            OP_ANDI, OP_ORI, OP_XORI: begin
                ctrl.use_imm      = 1'b1;
                ctrl.imm_zero_ext = 1'b1;
                ctrl.reg_write    = 1'b1;
                ctrl.alu_op       = (instr.i.opcode == OP_ANDI) ? ALU_AND :
                                    (instr.i.opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            // Effective address rs + sign-extended offset
            OP_LW: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_SW: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

//--- datapath/reg_file.sv
// General register file, 32 x 32 bits, two read ports, one write port, v0 tap
`timescale 1ns/1ps

module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  mips_isa_pkg::reg_idx_t raddr_a,
    input  mips_isa_pkg::reg_idx_t raddr_b,
    output mips_isa_pkg::word_t    rdata_a,
    output mips_isa_pkg::word_t    rdata_b,
    input  logic                   we,
    input  mips_isa_pkg::reg_idx_t waddr,
    input  mips_isa_pkg::word_t    wdata,
    output mips_isa_pkg::word_t    v0
);
    import mips_isa_pkg::*;

    word_t regs [32];

    // Register 0 is cleared by reset and never written, so it reads zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != REG_ZERO) begin
            regs[waddr] <= wdata;
        end
    end

    // Asynchronous reads
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];
    assign v0      = regs[REG_V0];

endmodule

//--- datapath/alu.sv
// ALU: add, subtract, logic, signed and unsigned compare, fixed shifts, upper immediate
`timescale 1ns/1ps

module alu (
    input  cpu_ctrl_pkg::alu_op_t op,
    input  mips_isa_pkg::word_t   a,
    input  mips_isa_pkg::word_t   b,
    input  logic [4:0]            shamt,
    output mips_isa_pkg::word_t   result,
    output logic                  zero
);
    import cpu_ctrl_pkg::*;

    always_comb begin
        case (op)
            // Wrapping arithmetic, no overflow trap
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'd0, a < b};
            // Shifts act on the rt operand
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = $unsigned($signed(b) >>> shamt);
            // Immediate into the upper half, low half cleared
            ALU_LUI:  result = {b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    // Equality test for BEQ and BNE
    assign zero = (result == '0);

endmodule

//--- common/cpu_ctrl_pkg.sv
// Core control types: FSM states, ALU operations, decoded control word, bus request, reset vector
package cpu_ctrl_pkg;

    // Multicycle sequence, one instruction in flight
    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC  = 2'd1,
        MEM   = 2'd2,
        HALT  = 2'd3
    } cpu_state_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9,
        ALU_LUI  = 4'd10
    } alu_op_t;

    // Decoded control for the instruction in the IR
    typedef struct packed {
        alu_op_t alu_op;
        // B operand is the extended immediate
        logic    use_imm;
        logic    imm_zero_ext;
        logic    reg_write;
        // Destination rd, else rt
        logic    dest_is_rd;
        // Write PC+4 into ra
        logic    link;
        logic    mem_read;
        logic    mem_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    jump_reg;
        logic    illegal;
    } ctrl_t;

    // Avalon master request, held unchanged while waitrequest is high
    typedef struct packed {
        mips_isa_pkg::word_t address;
        logic                read;
        logic                write;
        mips_isa_pkg::word_t writedata;
    } bus_req_t;

    localparam mips_isa_pkg::word_t DEFAULT_RESET_VECTOR = 32'hBFC0_0000;

endpackage

//--- common/mips_isa_pkg.sv
// MIPS I instruction set types: opcodes, function codes, field layouts, register numbers
package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Register numbers with a fixed role
    localparam reg_idx_t REG_ZERO = 5'd0;
    localparam reg_idx_t REG_V0   = 5'd2;
    localparam reg_idx_t REG_RA   = 5'd31;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_R     = 6'd0,
        OP_J     = 6'd2,
        OP_JAL   = 6'd3,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // SPECIAL group function codes
    typedef enum logic [5:0] {
        F_SLL  = 6'd0,
        F_SRL  = 6'd2,
        F_SRA  = 6'd3,
        F_JR   = 6'd8,
        F_ADDU = 6'd33,
        F_SUBU = 6'd35,
        F_AND  = 6'd36,
        F_OR   = 6'd37,
        F_XOR  = 6'd38,
        F_SLT  = 6'd42,
        F_SLTU = 6'd43
    } funct_t;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic [4:0] shamt;
        funct_t   funct;
    } r_fields_t;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] target;
    } j_fields_t;

    // One fetched word seen through each of the three encodings
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_t;

endpackage
